/* sim.f */
+incdir+verif
common/rsa_pkg.sv
montgomery/montgomery_mult.sv
montgomery/montgomery_prescale.sv
source/rsa_exp_ctrl.sv
source/rsa_core.sv
verif/tb_rsa_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the RSA core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rsa_core -f sim.f -o tb_rsa_core

# The simulator exits nonzero on a fatal check, the log decides
./obj_dir/tb_rsa_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation completed without failures"

/* verif/rsa_model.svh */
// RSA reference model
`ifndef RSA_MODEL_SVH
`define RSA_MODEL_SVH

// 256-bit random value from eight 32-bit draws
function automatic word_t draw_word(inout int seed);
    word_t w;
    w = '0;
    for (int i = 0; i < KEY_W / 32; i++) begin
        w[i*32 +: 32] = $random(seed);
    end
    return w;
endfunction

// Odd modulus with the top bit set
function automatic word_t make_modulus(inout int seed);
    word_t w;
    w = draw_word(seed);
    w[KEY_W-1] = 1'b1;
    w[0]       = 1'b1;
    return w;
endfunction

// Random text below the modulus
function automatic word_t draw_below(inout int seed, input word_t n);
    word_t w;
    w = draw_word(seed);
    return w % n;
endfunction

// ******************************
// Square and multiply, LSB first
// ******************************
function automatic word_t mod_exp(input word_t n, input word_t e, input word_t y);
    logic [2*KEY_W-1:0] modulus;
    logic [2*KEY_W-1:0] acc;
    logic [2*KEY_W-1:0] base;
    modulus = {{KEY_W{1'b0}}, n};
    acc     = (2*KEY_W)'(1);
    base    = {{KEY_W{1'b0}}, y} % modulus;
    for (int i = 0; i < KEY_W; i++) begin
        if (e[i]) begin
            acc = (acc * base) % modulus;
        end
        base = (base * base) % modulus;
    end
    return acc[KEY_W-1:0];
endfunction

`endif

/* verif/tb_rsa_core.sv */
// RSA core testbench
`timescale 1ns/1ps

module tb_rsa_core;
    import rsa_pkg::*;

    localparam int CLK_NS    = 4;
    localparam int NUM_OPS   = 18;
    localparam int OP_CYCLES = 257 + 256 * 262 + 20;
    // Ten percent margin over all operations
    localparam longint WATCHDOG_NS = longint'(NUM_OPS) * OP_CYCLES * CLK_NS * 11 / 10;

    logic  i_clk;
    logic  i_rst;
    logic  i_start;
    word_t i_n;
    word_t i_e;
    word_t i_text;
    word_t o_result;
    logic  o_done;
    logic  o_busy;

    int seed;
    int done_count;

    `include "rsa_model.svh"

    rsa_core DUT (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (i_start),
        .i_n      (i_n),
        .i_e      (i_e),
        .i_text   (i_text),
        .o_result (o_result),
        .o_done   (o_done),
        .o_busy   (o_busy)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
    end

    // Every cycle with o_done high
    always @(posedge i_clk) begin
        if (o_done) begin
            done_count <= done_count + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: o_done never came within the expected run time");
        $display("TB FAILED");
        $fatal(1, "Watchdog expired");
    end

    // ******************************
    // Helpers
    // ******************************
    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic apply_reset();
        i_rst   = 1'b1;
        i_start = 1'b0;
        repeat (3) @(negedge i_clk);
        i_rst = 1'b0;
    endtask

    task automatic check_idle(input string name);
        check_value({name, " busy"}, '0, word_t'(o_busy));
        check_value({name, " done"}, '0, word_t'(o_done));
        check_value({name, " result"}, '0, o_result);
    endtask

    task automatic start_op(input word_t n, input word_t e, input word_t y);
        i_start = 1'b1;
        i_n     = n;
        i_e     = e;
        i_text  = y;
        @(negedge i_clk);
        i_start = 1'b0;
    endtask

    task automatic wait_done();
        while (o_done !== 1'b1) begin
            @(negedge i_clk);
        end
    endtask

    task automatic run_op(input string name, input word_t n, input word_t e,
                          input word_t y, input word_t expected);
        int dones_before;
        dones_before = done_count;
        start_op(n, e, y);
        check_value({name, " busy"}, word_t'(1), word_t'(o_busy));
        wait_done();
        check_value({name, " result"}, expected, o_result);
        @(negedge i_clk);
        check_value({name, " done pulse"}, '0, word_t'(o_done));
        check_value({name, " done count"}, word_t'(dones_before + 1), word_t'(done_count));
    endtask

    // ******************************
    // Test sequence
    // ******************************
    initial begin
        word_t              n;
        word_t              e;
        word_t              y;
        word_t              expected;
        logic [2*KEY_W-1:0] sq;
        int                 dones_before;
        seed       = 32'hbc92;
        i_rst      = 1'b1;
        i_start    = 1'b0;
        i_n        = '0;
        i_e        = '0;
        i_text     = '0;
        apply_reset();
        check_idle("after reset");

        for (int k = 0; k < 10; k++) begin
            n = make_modulus(seed);
            e = draw_word(seed);
            y = draw_below(seed, n);
            run_op($sformatf("random %0d", k), n, e, y, mod_exp(n, e, y));
        end

        // Edge exponents
        n = make_modulus(seed);
        y = draw_below(seed, n);
        run_op("exp zero", n, '0, y, word_t'(1));
        run_op("exp one", n, word_t'(1), y, y);
        sq = ({{KEY_W{1'b0}}, y} * {{KEY_W{1'b0}}, y}) % {{KEY_W{1'b0}}, n};
        run_op("exp two", n, word_t'(2), y, sq[KEY_W-1:0]);

        // Edge bases
        e = draw_word(seed) | word_t'(1);
        run_op("base zero", n, e, '0, '0);
        run_op("base one", n, e, word_t'(1), word_t'(1));

        // Second start while busy must be dropped
        n            = make_modulus(seed);
        e            = draw_word(seed);
        y            = draw_below(seed, n);
        expected     = mod_exp(n, e, y);
        dones_before = done_count;
        start_op(n, e, y);
        repeat (50) @(negedge i_clk);
        check_value("busy start busy", word_t'(1), word_t'(o_busy));
        start_op(make_modulus(seed), draw_word(seed), word_t'(3));
        wait_done();
        check_value("busy start result", expected, o_result);
        repeat (20) @(negedge i_clk);
        check_value("busy start idle", '0, word_t'(o_busy));
        check_value("busy start done count", word_t'(dones_before + 1),
                    word_t'(done_count));

        // Reset in the middle of an operation
        n = make_modulus(seed);
        e = draw_word(seed);
        y = draw_below(seed, n);
        start_op(n, e, y);
        repeat (1000) @(negedge i_clk);
        apply_reset();
        check_idle("mid reset");
        run_op("after mid reset", n, e, y, mod_exp(n, e, y));

        $display("TB PASSED");
        $finish;
    end

endmodule

/* source/rsa_core.sv */
// RSA exponentiation core top
`timescale 1ns/1ps

module rsa_core (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  rsa_pkg::word_t i_n,
    input  rsa_pkg::word_t i_e,
    input  rsa_pkg::word_t i_text,
    output rsa_pkg::word_t o_result,
    output logic           o_done,
    output logic           o_busy
);
    import rsa_pkg::*;

    word_t n_reg;
    word_t text_reg;
    word_t scaled;
    word_t m_reg;
    word_t t_reg;
    word_t res_product;
    word_t sq_product;
    logic  pre_start;
    logic  pre_ready;
    logic  mult_start;
    logic  sq_ready;

    rsa_exp_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_n           (i_n),
        .i_e           (i_e),
        .i_text        (i_text),
        .i_scaled      (scaled),
        .i_pre_ready   (pre_ready),
        .i_res_product (res_product),
        .i_sq_product  (sq_product),
        .i_mult_ready  (sq_ready),
        .o_n           (n_reg),
        .o_text        (text_reg),
        .o_pre_start   (pre_start),
        .o_m           (m_reg),
        .o_t           (t_reg),
        .o_mult_start  (mult_start),
        .o_result      (o_result),
        .o_done        (o_done),
        .o_busy        (o_busy)
    );

    montgomery_prescale u_prescale (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_start  (pre_start),
        .i_n      (n_reg),
        .i_y      (text_reg),
        .o_scaled (scaled),
        .o_ready  (pre_ready)
    );

    // ******************************
    // Multiply and square in parallel
    // ******************************
    // Same fixed latency, the controller follows u_mult_sq only
    montgomery_mult u_mult_res (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_valid   (mult_start),
        .i_n       (n_reg),
        .i_a       (m_reg),
        .i_b       (t_reg),
        .o_product (res_product),
        .o_ready   ()
    );

    montgomery_mult u_mult_sq (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_valid   (mult_start),
        .i_n       (n_reg),
        .i_a       (t_reg),
        .i_b       (t_reg),
        .o_product (sq_product),
        .o_ready   (sq_ready)
    );

endmodule

/* source/rsa_exp_ctrl.sv */
// Modular exponentiation controller
`timescale 1ns/1ps

module rsa_exp_ctrl (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  rsa_pkg::word_t i_n,
    input  rsa_pkg::word_t i_e,
    input  rsa_pkg::word_t i_text,
    input  rsa_pkg::word_t i_scaled,
    input  logic           i_pre_ready,
    input  rsa_pkg::word_t i_res_product,
    input  rsa_pkg::word_t i_sq_product,
    input  logic           i_mult_ready,
    output rsa_pkg::word_t o_n,
    output rsa_pkg::word_t o_text,
    output logic           o_pre_start,
    output rsa_pkg::word_t o_m,
    output rsa_pkg::word_t o_t,
    output logic           o_mult_start,
    output rsa_pkg::word_t o_result,
    output logic           o_done,
    output logic           o_busy
);
    import rsa_pkg::*;

    exp_state_t state;
    count_t     bit_cnt;
    logic       pre_start;
    logic       mult_start;
    logic       done;
    logic       busy;
    word_t      result;
    word_t      n_q;
    word_t      e_q;
    word_t      y_q;
    word_t      m_q;
    word_t      t_q;

    assign o_n          = n_q;
    assign o_text       = y_q;
    assign o_m          = m_q;
    assign o_t          = t_q;
    assign o_pre_start  = pre_start;
    assign o_mult_start = mult_start;
    assign o_result     = result;
    assign o_done       = done;
    assign o_busy       = busy;

    // ******************************
    // Sequencer
    // ******************************
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            pre_start  <= 1'b0;
            mult_start <= 1'b0;
            done       <= 1'b0;
            busy       <= 1'b0;
            result     <= '0;
        end else begin
            pre_start  <= 1'b0;
            mult_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) begin
                        pre_start <= 1'b1;
                        busy      <= 1'b1;
                        state     <= PRESCALE;
                    end
                end
                PRESCALE: begin
                    if (i_pre_ready) begin
                        bit_cnt <= '0;
                        state   <= MULT;
                    end
                end
                MULT: begin
                    mult_start <= 1'b1;
                    state      <= WAIT;
                end
                WAIT: begin
                    if (i_mult_ready) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == EXP_LAST_BIT) begin
                            state <= DONE;
                        end else begin
                            state <= MULT;
                        end
                    end
                end
                DONE: begin
                    result <= m_q;
                    done   <= 1'b1;
                    busy   <= 1'b0;
                    state  <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ******************************
    // Operands
    // ******************************
    always_ff @(posedge i_clk) begin
        case (state)
            IDLE: begin
                if (i_start) begin
                    n_q <= i_n;
                    e_q <= i_e;
                    y_q <= i_text;
                end
            end
            PRESCALE: begin
                if (i_pre_ready) begin
                    t_q <= i_scaled;
                    m_q <= word_t'(1);
                end
            end
            WAIT: begin
                // Square always, multiply only on a set bit
                if (i_mult_ready) begin
                    t_q <= i_sq_product;
                    if (e_q[0]) begin
                        m_q <= i_res_product;
                    end
                    e_q <= e_q >> 1;
                end
            end
            default: begin
                n_q <= n_q;
            end
        endcase
    end

    // Multipliers read these for the whole pass
    a_operands_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (state == WAIT) |-> ($stable(m_q) && $stable(t_q) && $stable(n_q)));

endmodule

/* montgomery/montgomery_prescale.sv */
// Montgomery domain pre-scaler
`timescale 1ns/1ps

module montgomery_prescale (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_start,
    input  rsa_pkg::word_t i_n,
    input  rsa_pkg::word_t i_y,
    output rsa_pkg::word_t o_scaled,
    output logic           o_ready
);
    import rsa_pkg::*;

    logic   run;
    logic   ready;
    count_t cnt;
    word_t  val;
    wide_t  dbl;
    wide_t  red;

    assign o_scaled = val;
    assign o_ready  = ready;

    // Double, then pull back below N
    always_comb begin
        dbl = wide_t'(val) << 1;
        red = (dbl >= wide_t'(i_n)) ? dbl - wide_t'(i_n) : dbl;
    end

    // ******************************
    // Step counter
    // ******************************
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            run   <= 1'b0;
            cnt   <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (!run) begin
                if (i_start) begin
                    run <= 1'b1;
                    cnt <= '0;
                end
            end else begin
                cnt <= cnt + 1'b1;
                if (cnt == PRE_LAST_STEP) begin
                    run   <= 1'b0;
                    ready <= 1'b1;
                end
            end
        end
    end

    // Value register, held after the last step
    always_ff @(posedge i_clk) begin
        if (!run && i_start) begin
            val <= i_y;
        end else if (run) begin
            val <= red[KEY_W-1:0];
        end
    end

    a_scaled_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
        o_ready |-> (o_scaled < i_n));

endmodule

/* montgomery/montgomery_mult.sv */
// Montgomery multiplier
`timescale 1ns/1ps

module montgomery_mult (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_valid,
    input  rsa_pkg::word_t i_n,
    input  rsa_pkg::word_t i_a,
    input  rsa_pkg::word_t i_b,
    output rsa_pkg::word_t o_product,
    output logic           o_ready
);
    import rsa_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_CALC,
        S_OUT
    } mult_state_t;

    mult_state_t state;
    mult_state_t state_nxt;
    count_t      cnt;
    count_t      cnt_nxt;
    logic        ready;
    logic        ready_nxt;
    wide_t       acc;
    wide_t       sum_add;
    wide_t       sum_odd;

    assign o_product = acc[KEY_W-1:0];
    assign o_ready   = ready;

    // ******************************
    // Control
    // ******************************
    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        ready_nxt = 1'b0;
        case (state)
            S_IDLE: begin
                cnt_nxt = '0;
                if (i_valid) begin
                    state_nxt = S_CALC;
                end
            end
            S_CALC: begin
                cnt_nxt = cnt + 1'b1;
                if (cnt == MULT_LAST_STEP) begin
                    state_nxt = S_OUT;
                end
            end
            S_OUT: begin
                cnt_nxt = cnt + 1'b1;
                if (cnt == MULT_RDY_STEP) begin
                    ready_nxt = 1'b1;
                end
                if (cnt == MULT_END_STEP) begin
                    cnt_nxt   = '0;
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= S_IDLE;
            cnt   <= '0;
            ready <= 1'b0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
            ready <= ready_nxt;
        end
    end

    // ******************************
    // Datapath
    // ******************************
    // One radix-2 step, LSB of a first
    always_comb begin
        sum_add = acc + (i_a[cnt[CNT_W-2:0]] ? wide_t'(i_b) : '0);
        sum_odd = sum_add[0] ? sum_add + wide_t'(i_n) : sum_add;
    end

    always_ff @(posedge i_clk) begin
        case (state)
            S_IDLE: begin
                if (i_valid) begin
                    acc <= '0;
                end
            end
            S_CALC: begin
                acc <= sum_odd >> 1;
            end
            S_OUT: begin
                // Final correction, acc < 2N here
                if (cnt == MULT_SUB_STEP && acc >= wide_t'(i_n)) begin
                    acc <= acc - wide_t'(i_n);
                end
            end
            default: begin
                acc <= acc;
            end
        endcase
    end

    a_ready_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_ready |=> !o_ready);

    // A new request mid-pass must not restart the count
    a_valid_ignored: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_valid && state != S_IDLE && cnt != MULT_END_STEP)
            |=> cnt == count_t'($past(cnt) + 1'b1));

endmodule

/* common/rsa_pkg.sv */
// RSA core shared definitions
package rsa_pkg;

    // ******************************
    // Widths
    // ******************************
    localparam int KEY_W = 256;
    localparam int CNT_W = 9;

    typedef logic [KEY_W-1:0] word_t;
    // Two guard bits for a + b + N before halving
    typedef logic [KEY_W+1:0] wide_t;
    typedef logic [CNT_W-1:0] count_t;

    // ******************************
    // Step counts
    // ******************************
    // Multiplier: last add step, subtract step, ready step, end of pass
    localparam count_t MULT_LAST_STEP = count_t'(KEY_W - 1);
    localparam count_t MULT_SUB_STEP  = count_t'(KEY_W);
    localparam count_t MULT_RDY_STEP  = count_t'(KEY_W + 1);
    localparam count_t MULT_END_STEP  = count_t'(KEY_W + 2);

    // Pre-scaler doubling steps
    localparam count_t PRE_LAST_STEP = count_t'(KEY_W - 1);

    // Exponent bits scanned by the controller
    localparam count_t EXP_LAST_BIT = count_t'(KEY_W - 1);

    // ******************************
    // Controller states
    // ******************************
    typedef enum logic [2:0] {
        IDLE,
        PRESCALE,
        MULT,
        WAIT,
        DONE
    } exp_state_t;

endpackage
